/* include/adc_regs.svh */
`ifndef ADC_REGS_SVH
`define ADC_REGS_SVH

// wishbone register offsets
`define ADC_REG_BYPASS_HI 16'd0 // channels 31..16
`define ADC_REG_BYPASS_LO 16'd1 // channels 15..0
`define ADC_REG_CMON_EN   16'd2
`define ADC_REG_TMON_EN   16'd3
`define ADC_REG_EN        16'd4
`define ADC_REG_AVG       16'd5
`define ADC_REG_STATUS    16'd6

`endif

/* src/adc_pkg.sv */
package adc_pkg;

  localparam int NUM_CH   = 32;
  localparam int CH_W     = 5;
  localparam int SAMPLE_W = 12;
  localparam int ACC_W    = SAMPLE_W + 4; // room for 16 samples

  localparam int NUM_CMON = 10;
  localparam int NUM_TMON = 11;

  // coding is visible in the status register
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    STROBE  = 3'd1,
    CONVERT = 3'd2,
    WAITING = 3'd3,
    DONE    = 3'd4
  } seq_state_e;

  typedef enum logic [2:0] {
    SRC_BYPASS_HI = 3'd0,
    SRC_BYPASS_LO = 3'd1,
    SRC_CMON      = 3'd2,
    SRC_TMON      = 3'd3,
    SRC_EN        = 3'd4,
    SRC_AVG       = 3'd5,
    SRC_STATUS    = 3'd6,
    SRC_ZERO      = 3'd7
  } rd_src_e;

endpackage

/* src/adc_cfg_if.sv */
`timescale 1ns/1ps

interface adc_cfg_if;
  import adc_pkg::*;

  logic [NUM_CH-1:0]   channel_bypass;
  logic [NUM_CMON-1:0] cmon_en;
  logic [NUM_TMON-1:0] tmon_en;
  logic                adc_en;
  logic [2:0]          avg_code;
  seq_state_e          state; // back to status reg

  modport regs (
    output channel_bypass, cmon_en, tmon_en, adc_en, avg_code,
    input  state
  );

  modport seq (
    input  channel_bypass, cmon_en, tmon_en, adc_en, avg_code,
    output state
  );

endinterface

/* src/adc_wb_regs.sv */
`timescale 1ns/1ps

`include "adc_regs.svh"

module adc_wb_regs #(
  parameter int unsigned DEFAULT_AVG = 4
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [15:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        adc_busy_i,
  input  logic        adc_sample_i,
  input  logic        adc_dv_i,
  input  logic        adc_cal_i,
  adc_cfg_if.regs     cfg
);
  import adc_pkg::*;

  rd_src_e rd_src;
  logic    access;

  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o           <= 1'b0;
      rd_src             <= SRC_ZERO;
      cfg.channel_bypass <= '0;
      cfg.cmon_en        <= '1;
      cfg.tmon_en        <= '1;
      cfg.adc_en         <= 1'b1;
      cfg.avg_code       <= 3'(DEFAULT_AVG);
    end else begin
      wb_ack_o <= access; // single cycle ack
      if (access) begin
        case (wb_adr_i)
          `ADC_REG_BYPASS_HI: begin
            rd_src <= SRC_BYPASS_HI;
            if (wb_we_i) cfg.channel_bypass[31:16] <= wb_dat_i;
          end
          `ADC_REG_BYPASS_LO: begin
            rd_src <= SRC_BYPASS_LO;
            if (wb_we_i) cfg.channel_bypass[15:0] <= wb_dat_i;
          end
          `ADC_REG_CMON_EN: begin
            rd_src <= SRC_CMON;
            if (wb_we_i) cfg.cmon_en <= wb_dat_i[NUM_CMON-1:0];
          end
          `ADC_REG_TMON_EN: begin
            rd_src <= SRC_TMON;
            if (wb_we_i) cfg.tmon_en <= wb_dat_i[NUM_TMON-1:0];
          end
          `ADC_REG_EN: begin
            rd_src <= SRC_EN;
            if (wb_we_i) cfg.adc_en <= wb_dat_i[0];
          end
          `ADC_REG_AVG: begin
            rd_src <= SRC_AVG;
            if (wb_we_i) cfg.avg_code <= wb_dat_i[2:0];
          end
          `ADC_REG_STATUS: rd_src <= SRC_STATUS; // read only
          default:         rd_src <= SRC_ZERO;
        endcase
      end
    end
  end

  // read mux, valid while ack is high
  always_comb begin
    case (rd_src)
      SRC_BYPASS_HI: wb_dat_o = cfg.channel_bypass[31:16];
      SRC_BYPASS_LO: wb_dat_o = cfg.channel_bypass[15:0];
      SRC_CMON:      wb_dat_o = {{(16-NUM_CMON){1'b0}}, cfg.cmon_en};
      SRC_TMON:      wb_dat_o = {{(16-NUM_TMON){1'b0}}, cfg.tmon_en};
      SRC_EN:        wb_dat_o = {15'b0, cfg.adc_en};
      SRC_AVG:       wb_dat_o = {13'b0, cfg.avg_code};
      SRC_STATUS: begin
        wb_dat_o = {9'b0, cfg.state, adc_busy_i, adc_sample_i, adc_dv_i, adc_cal_i};
      end
      default:       wb_dat_o = 16'h0000;
    endcase
  end

endmodule

/* src/adc_sequencer.sv */
`timescale 1ns/1ps

module adc_sequencer #(
  parameter int unsigned STB_WIDTH = 400
) (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  adc_cfg_if.seq                        cfg,
  output logic                          adc_start_o,
  output logic [adc_pkg::CH_W-1:0]      adc_chnum_o,
  input  logic                          adc_busy_i,
  input  logic                          adc_dv_i,
  input  logic                          adc_cal_i,
  input  logic [adc_pkg::SAMPLE_W-1:0]  adc_result_i,
  output logic                          sample_valid_o,
  output logic [adc_pkg::SAMPLE_W-1:0]  sample_o,
  input  logic                          group_done_i,
  output logic [adc_pkg::NUM_CMON-1:0]  cmon_stb_o,
  output logic [adc_pkg::NUM_TMON-1:0]  tmon_stb_o
);
  import adc_pkg::*;

  localparam int CNT_W = (STB_WIDTH > 0) ? $clog2(STB_WIDTH + 1) : 1;

  seq_state_e          state;
  logic [CNT_W-1:0]    stb_cnt;
  logic [NUM_CMON-1:0] cmon_sel;
  logic [NUM_TMON-1:0] tmon_sel;
  logic [NUM_CMON-1:0] cmon_hit;
  logic [NUM_TMON-1:0] tmon_hit;
  logic                dv_q;
  logic                dv_rise;
  logic                capture;
  logic                grp_last; // advance channel in DONE

  // current k -> ch 3k+2, temp k -> ch 3k+3, last temp -> ch 31
  always_comb begin
    cmon_sel = '0;
    tmon_sel = '0;
    for (int k = 0; k < NUM_CMON; k++) begin
      cmon_sel[k] = (adc_chnum_o == CH_W'(3*k + 2));
    end
    for (int k = 0; k < NUM_TMON-1; k++) begin
      tmon_sel[k] = (adc_chnum_o == CH_W'(3*k + 3));
    end
    tmon_sel[NUM_TMON-1] = (adc_chnum_o == CH_W'(NUM_CH - 1));
  end

  assign cmon_hit = cmon_sel & cfg.cmon_en;
  assign tmon_hit = tmon_sel & cfg.tmon_en;

  // result is taken on the first cycle of datavalid only
  assign dv_rise = adc_dv_i & ~dv_q;
  assign capture = dv_rise & ((state == CONVERT) | (state == WAITING));

  assign sample_valid_o = capture;
  assign sample_o       = adc_result_i;
  assign cfg.state      = state;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state       <= IDLE;
      adc_start_o <= 1'b0;
      adc_chnum_o <= '0;
      cmon_stb_o  <= '0;
      tmon_stb_o  <= '0;
      dv_q        <= 1'b0;
      grp_last    <= 1'b0;
    end else begin
      dv_q <= adc_dv_i;
      case (state)
        IDLE: begin
          if (cfg.adc_en & ~adc_cal_i) begin
            if (cfg.channel_bypass[adc_chnum_o]) begin
              grp_last <= 1'b1;
              state    <= DONE;
            end else if ((|cmon_hit) | (|tmon_hit)) begin
              stb_cnt    <= CNT_W'(STB_WIDTH);
              cmon_stb_o <= cmon_hit;
              tmon_stb_o <= tmon_hit;
              state      <= STROBE;
            end else begin
              adc_start_o <= 1'b1;
              state       <= CONVERT;
            end
          end
        end
        STROBE: begin
          if (stb_cnt != '0) begin
            stb_cnt <= stb_cnt - 1'b1;
          end else begin
            adc_start_o <= 1'b1; // settling done
            state       <= CONVERT;
          end
        end
        CONVERT, WAITING: begin
          if (capture) begin
            adc_start_o <= 1'b0;
            cmon_stb_o  <= '0;
            tmon_stb_o  <= '0;
            grp_last    <= group_done_i;
            state       <= DONE;
          end else if (adc_busy_i) begin
            adc_start_o <= 1'b0;
            state       <= WAITING;
          end
        end
        DONE: begin
          if (grp_last) adc_chnum_o <= adc_chnum_o + 1'b1; // wraps 31 -> 0
          grp_last <= 1'b0;
          state    <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* src/adc_averager.sv */
`timescale 1ns/1ps

module adc_averager (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic [2:0]                    avg_code_i,
  input  logic                          sample_valid_i,
  input  logic [adc_pkg::SAMPLE_W-1:0]  sample_i,
  output logic                          group_done_o,
  output logic [adc_pkg::SAMPLE_W-1:0]  result_o,
  output logic                          strb_o
);
  import adc_pkg::*;

  logic [2:0]       shift;
  logic [3:0]       last_cnt;
  logic [3:0]       cnt;
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] sum_next;

  // codes above 4 saturate at 16 samples
  assign shift    = (avg_code_i > 3'd4) ? 3'd4 : avg_code_i;
  assign last_cnt = 4'((5'd1 << shift) - 5'd1);

  assign group_done_o = (cnt >= last_cnt);
  assign sum_next     = ((cnt == '0) ? '0 : acc) + ACC_W'(sample_i); // fresh sum at group start

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cnt    <= '0;
      strb_o <= 1'b0;
    end else begin
      strb_o <= 1'b0;
      if (sample_valid_i) begin
        if (group_done_o) begin
          cnt    <= '0;
          strb_o <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (sample_valid_i) begin
      acc <= sum_next;
      if (group_done_o) result_o <= SAMPLE_W'(sum_next >> shift); // floor of mean
    end
  end

endmodule

/* src/adc_subsystem_top.sv */
`timescale 1ns/1ps

module adc_subsystem_top #(
  parameter int unsigned STB_WIDTH   = 400,
  parameter int unsigned DEFAULT_AVG = 4
) (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [15:0]                   wb_adr_i,
  input  logic [15:0]                   wb_dat_i,
  output logic [15:0]                   wb_dat_o,
  output logic                          wb_ack_o,
  output logic [adc_pkg::SAMPLE_W-1:0]  adc_result_o,
  output logic [adc_pkg::CH_W-1:0]      adc_channel_o,
  output logic                          adc_strb_o,
  output logic [adc_pkg::NUM_CMON-1:0]  cmon_stb_o,
  output logic [adc_pkg::NUM_TMON-1:0]  tmon_stb_o,
  output logic                          adc_start_o,
  output logic [adc_pkg::CH_W-1:0]      adc_chnum_o,
  input  logic                          adc_cal_i,
  input  logic                          adc_dv_i,
  input  logic                          adc_busy_i,
  input  logic                          adc_sample_i,
  input  logic [adc_pkg::SAMPLE_W-1:0]  adc_data_i
);
  import adc_pkg::*;

  logic                sample_valid;
  logic [SAMPLE_W-1:0] sample;
  logic                group_done;

  adc_cfg_if cfg_if ();

  adc_wb_regs #(
    .DEFAULT_AVG (DEFAULT_AVG)
  ) adc_wb_regs_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .adc_busy_i   (adc_busy_i),
    .adc_sample_i (adc_sample_i),
    .adc_dv_i     (adc_dv_i),
    .adc_cal_i    (adc_cal_i),
    .cfg          (cfg_if.regs)
  );

  adc_sequencer #(
    .STB_WIDTH (STB_WIDTH)
  ) adc_sequencer_i (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .cfg            (cfg_if.seq),
    .adc_start_o    (adc_start_o),
    .adc_chnum_o    (adc_chnum_o),
    .adc_busy_i     (adc_busy_i),
    .adc_dv_i       (adc_dv_i),
    .adc_cal_i      (adc_cal_i),
    .adc_result_i   (adc_data_i),
    .sample_valid_o (sample_valid),
    .sample_o       (sample),
    .group_done_i   (group_done),
    .cmon_stb_o     (cmon_stb_o),
    .tmon_stb_o     (tmon_stb_o)
  );

  adc_averager adc_averager_i (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .avg_code_i     (cfg_if.avg_code),
    .sample_valid_i (sample_valid),
    .sample_i       (sample),
    .group_done_o   (group_done),
    .result_o       (adc_result_o),
    .strb_o         (adc_strb_o)
  );

  assign adc_channel_o = adc_chnum_o; // channel advances after the strobe

endmodule

/* dv/adc_checker.sv */
`timescale 1ns/1ps

module adc_checker (
  input logic                          wb_clk_i,
  input logic                          wb_rst_i,
  input logic                          adc_start_i,
  input logic                          adc_busy_i,
  input logic                          adc_dv_i,
  input adc_pkg::seq_state_e           state_i,
  input logic [adc_pkg::NUM_CMON-1:0]  cmon_stb_i,
  input logic [adc_pkg::NUM_TMON-1:0]  tmon_stb_i
);
  import adc_pkg::*;

  start_not_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(adc_start_i) |-> !adc_busy_i)
    else $error("start rose while the ADC was busy");

  // start stays up until the macro answers
  start_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (adc_start_i && !adc_busy_i && !adc_dv_i) |=> adc_start_i)
    else $error("start dropped before busy or datavalid");

  mon_in_state: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ((|cmon_stb_i) || (|tmon_stb_i)) |-> (state_i inside {STROBE, CONVERT, WAITING}))
    else $error("monitor strobe outside a conversion");

  mon_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0({cmon_stb_i, tmon_stb_i}))
    else $error("more than one monitor strobe high");

endmodule

bind adc_sequencer adc_checker adc_checker_i (
  .wb_clk_i    (wb_clk_i),
  .wb_rst_i    (wb_rst_i),
  .adc_start_i (adc_start_o),
  .adc_busy_i  (adc_busy_i),
  .adc_dv_i    (adc_dv_i),
  .state_i     (state),
  .cmon_stb_i  (cmon_stb_o),
  .tmon_stb_i  (tmon_stb_o)
);

/* dv/adc_tb.sv */
`timescale 1ns/1ps

`include "adc_regs.svh"

module adc_tb;
  import adc_pkg::*;

  localparam int STB_W = 12;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [15:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic [11:0] adc_result_o;
  logic [4:0]  adc_channel_o;
  logic        adc_strb_o;
  logic [9:0]  cmon_stb_o;
  logic [10:0] tmon_stb_o;
  logic        adc_start_o;
  logic [4:0]  adc_chnum_o;
  logic        adc_cal_i;
  logic        adc_dv_i = 1'b0;
  logic        adc_busy_i = 1'b0;
  logic        adc_sample_i;
  logic [11:0] adc_data_i = '0;

  // testbench view of the configuration
  logic [31:0] bypass;
  logic [9:0]  cmon_en_t;
  logic [10:0] tmon_en_t;
  int unsigned cur_shift;
  int unsigned exp_ch;
  int unsigned result_cnt = 0;
  int unsigned start_rises = 0;
  int unsigned hi_cnt;
  logic        start_q;
  logic        strb_q = 1'b0;

  // behavioral ADC macro
  int unsigned m_state = 0;
  int unsigned m_wait;
  int unsigned conv_cnt = 0;
  logic [4:0]  m_ch;
  logic [11:0] m_val;
  logic [11:0] sent_val[$];
  logic [4:0]  sent_ch[$];

  adc_subsystem_top #(
    .STB_WIDTH   (STB_W),
    .DEFAULT_AVG (0)
  ) adc_subsystem_top_i (.*);

  always #50 wb_clk_i = ~wb_clk_i;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail %0t %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  function automatic logic [11:0] ref_avg(input int unsigned shift);
    int unsigned sum;
    sum = 0;
    foreach (sent_val[i]) sum += sent_val[i];
    return 12'(sum >> shift);
  endfunction

  function automatic int unsigned next_ch(input int unsigned from);
    int unsigned c;
    for (int i = 0; i < 32; i++) begin
      c = (from + i) % 32;
      if (!bypass[c]) return c;
    end
    return from % 32;
  endfunction

  function automatic logic [9:0] exp_cmon(input int unsigned ch);
    logic [9:0] m;
    m = '0;
    for (int k = 0; k < 10; k++) m[k] = (ch == 3*k + 2) && cmon_en_t[k];
    return m;
  endfunction

  function automatic logic [10:0] exp_tmon(input int unsigned ch);
    logic [10:0] m;
    m = '0;
    for (int k = 0; k < 10; k++) m[k] = (ch == 3*k + 3) && tmon_en_t[k];
    m[10] = (ch == 31) && tmon_en_t[10];
    return m;
  endfunction

  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      m_state    <= 0;
      adc_busy_i <= 1'b0;
      adc_dv_i   <= 1'b0;
    end else begin
      case (m_state)
        0: if (adc_start_o) begin
          m_ch    <= adc_chnum_o;
          m_wait  <= $urandom_range(3, 1);
          m_state <= 1;
        end
        1: if (m_wait == 1) begin
          adc_busy_i <= 1'b1;
          m_wait     <= $urandom_range(20, 5);
          m_state    <= 2;
        end else m_wait <= m_wait - 1;
        2: if (m_wait == 1) begin
          m_val = 12'((m_ch * 100 + conv_cnt) % 4096);
          sent_val.push_back(m_val); // log of samples of this group
          sent_ch.push_back(m_ch);
          conv_cnt   <= conv_cnt + 1;
          adc_busy_i <= 1'b0;
          adc_dv_i   <= 1'b1;
          adc_data_i <= m_val;
          m_state    <= 3;
        end else m_wait <= m_wait - 1;
        default: begin
          adc_dv_i <= 1'b0;
          m_state  <= 0;
        end
      endcase
    end
  end

  // compare on every result strobe
  always @(posedge wb_clk_i) begin
    if (!wb_rst_i && adc_strb_o) begin
      check_eq("adc_strb_o length", strb_q, 0);
      check_eq("group size", sent_val.size(), 1 << cur_shift);
      foreach (sent_ch[i]) check_eq("sample channel", sent_ch[i], adc_channel_o);
      check_eq("adc_channel_o", adc_channel_o, exp_ch);
      check_eq("adc_result_o", adc_result_o, ref_avg(cur_shift));
      check_eq("cmon_stb_o", cmon_stb_o, 0);
      check_eq("tmon_stb_o", tmon_stb_o, 0);
      sent_val.delete();
      sent_ch.delete();
      exp_ch = next_ch(exp_ch + 1);
      result_cnt++;
    end
    strb_q = adc_strb_o;
  end

  // monitor strobes and bypass at each start
  always @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      hi_cnt  = 0;
      start_q = 1'b0;
    end else begin
      if ((|cmon_stb_o) || (|tmon_stb_o)) hi_cnt++;
      else hi_cnt = 0;
      if (adc_start_o) check_eq("bypass of adc_chnum_o", bypass[adc_chnum_o], 0);
      if (adc_start_o && !start_q) begin
        start_rises++;
        check_eq("cmon_stb_o", cmon_stb_o, exp_cmon(adc_chnum_o));
        check_eq("tmon_stb_o", tmon_stb_o, exp_tmon(adc_chnum_o));
        if ((|cmon_stb_o) || (|tmon_stb_o)) check_eq("strobe length", hi_cnt >= STB_W, 1);
      end
      start_q = adc_start_o;
    end
  end

  task automatic wb_access(input logic we_v, input logic [15:0] adr_v,
                           input logic [15:0] dat_v, output logic [15:0] rd_v);
    int n;
    n = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we_v;
    wb_adr_i <= adr_v;
    wb_dat_i <= dat_v;
    do begin
      @(posedge wb_clk_i);
      n++;
      if (n > 20) stop_run("no Wishbone ack within 20 cycles");
    end while (!wb_ack_o);
    rd_v = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [15:0] adr_v, input logic [15:0] dat_v);
    logic [15:0] unused;
    wb_access(1'b1, adr_v, dat_v, unused);
  endtask

  task automatic read_expect(input logic [15:0] adr_v, input logic [15:0] exp);
    logic [15:0] rd;
    wb_access(1'b0, adr_v, 16'h0, rd);
    check_eq("wb_dat_o", rd, exp);
  endtask

  task automatic wait_results(input int unsigned n);
    int unsigned target;
    int unsigned t;
    target = result_cnt + n;
    t = 0;
    while (result_cnt < target) begin
      @(posedge wb_clk_i);
      t++;
      if (t > n * 2000) stop_run("timeout waiting for result strobes");
    end
  endtask

  // wait for IDLE, then no start may follow
  task automatic expect_stopped(input logic cal_v);
    logic [15:0] rd;
    int n;
    int unsigned rises;
    n = 0;
    do begin
      wb_access(1'b0, `ADC_REG_STATUS, 16'h0, rd);
      n++;
      if (n > 100) stop_run("sequencer did not return to IDLE");
    end while (rd[6:4] != 3'(IDLE));
    check_eq("status calibrate", rd[0], cal_v);
    rises = start_rises;
    repeat (40) @(posedge wb_clk_i);
    check_eq("start rises while stopped", start_rises, rises);
  endtask

  task automatic set_avg(input logic [15:0] code, input int unsigned shift);
    wait_results(1); // group boundary
    wb_write(`ADC_REG_AVG, code);
    cur_shift = shift;
  endtask

  initial begin
    void'($urandom(9));
    wb_rst_i     = 1'b1;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    adc_cal_i    = 1'b0;
    adc_sample_i = 1'b0;
    bypass       = '0;
    cmon_en_t    = '1;
    tmon_en_t    = '1;
    cur_shift    = 0;
    exp_ch       = 0;
    repeat (8) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    read_expect(`ADC_REG_BYPASS_HI, 16'h0000);
    read_expect(`ADC_REG_BYPASS_LO, 16'h0000);
    read_expect(`ADC_REG_CMON_EN, 16'h03ff);
    read_expect(`ADC_REG_TMON_EN, 16'h07ff);
    read_expect(`ADC_REG_EN, 16'h0001);
    read_expect(`ADC_REG_AVG, 16'h0000);
    read_expect(16'd9, 16'h0000);
    wait_results(40); // full scan with wrap

    wb_write(`ADC_REG_EN, 16'h0000);
    expect_stopped(1'b0);
    read_expect(`ADC_REG_EN, 16'h0000);
    wb_write(`ADC_REG_BYPASS_HI, 16'ha5a5);
    read_expect(`ADC_REG_BYPASS_HI, 16'ha5a5);
    wb_write(`ADC_REG_BYPASS_LO, 16'h5a5a);
    read_expect(`ADC_REG_BYPASS_LO, 16'h5a5a);
    wb_write(`ADC_REG_CMON_EN, 16'hffff);
    read_expect(`ADC_REG_CMON_EN, 16'h03ff);
    wb_write(`ADC_REG_TMON_EN, 16'hffff);
    read_expect(`ADC_REG_TMON_EN, 16'h07ff);
    wb_write(`ADC_REG_AVG, 16'hffff);
    read_expect(`ADC_REG_AVG, 16'h0007);

    // bypass 5, 8, 26 and drop some monitors
    wb_write(`ADC_REG_AVG, 16'h0000);
    wb_write(`ADC_REG_BYPASS_HI, 16'h0400);
    wb_write(`ADC_REG_BYPASS_LO, 16'h0120);
    wb_write(`ADC_REG_CMON_EN, 16'h03f5);
    wb_write(`ADC_REG_TMON_EN, 16'h03fb);
    bypass    = 32'h0400_0120;
    cmon_en_t = 10'h3f5;
    tmon_en_t = 11'h3fb;
    exp_ch    = next_ch(exp_ch);
    wb_write(`ADC_REG_EN, 16'h0001);
    wait_results(40);

    set_avg(16'd2, 2);
    wait_results(12);
    set_avg(16'd6, 4);
    wait_results(4);

    // pause in the middle of a group
    wb_write(`ADC_REG_EN, 16'h0000);
    expect_stopped(1'b0);
    wb_write(`ADC_REG_EN, 16'h0001);
    wait_results(2);

    @(posedge wb_clk_i);
    adc_cal_i <= 1'b1;
    expect_stopped(1'b1);
    @(posedge wb_clk_i);
    adc_cal_i <= 1'b0;
    wait_results(3);

    $display("Everything OK");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
src/adc_pkg.sv
src/adc_cfg_if.sv
src/adc_wb_regs.sv
src/adc_sequencer.sv
src/adc_averager.sv
src/adc_subsystem_top.sv
dv/adc_checker.sv
dv/adc_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module adc_tb -o adc_sim
	out=$$(./obj_dir/adc_sim); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
